//--- Makefile
TOP := packet_merger_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "test FAILED"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- compile.f
hdl/merge_cfg_pkg.sv
hdl/flit_pkg.sv
hdl/lane_if.sv
hdl/beat_if.sv
hdl/lane_ingress.sv
hdl/packet_fanin_arbiter.sv
hdl/credit_egress.sv
hdl/packet_merger_top.sv
test/packet_merger_tb.sv

//--- hdl/beat_if.sv
`timescale 1ns/1ps

interface beat_if import flit_pkg::*; ();

  // merged beat, valid/ready handshake
  logic              valid;
  logic [BEAT_W-1:0] data;
  logic              last;

  // from the egress
  logic              ready;

  modport source (
    output valid, data, last,
    input  ready
  );

  modport sink (
    input  valid, data, last,
    output ready
  );

endinterface

//--- hdl/credit_egress.sv
`timescale 1ns/1ps

module credit_egress import merge_cfg_pkg::*, flit_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  beat_if.sink              in,
  output logic              out_valid,
  output logic [BEAT_W-1:0] out_data,
  output logic              out_last,
  input  logic              out_credit_grant
);

  logic [OUT_CREDIT_W-1:0] credits;
  logic                    hold_valid;
  logic [BEAT_W-1:0]       hold_data;
  logic                    hold_last;
  logic                    send;
  logic                    load;

  // a held beat goes out whenever a credit is there
  assign send = hold_valid && (credits != '0);
  // empty, or emptying this cycle
  assign in.ready = !hold_valid || send;
  assign load = in.valid && in.ready;

  ////////////////////
  // credit counter
  ////////////////////

  // grant and send in one cycle cancel out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= '0;
    end else begin
      case ({out_credit_grant, send})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  ////////////////////
  // beat register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_valid <= 1'b0;
    end else if (load) begin
      hold_valid <= 1'b1;
    end else if (send) begin
      hold_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      hold_data <= in.data;
      hold_last <= in.last;
    end
  end

  // single cycle per beat, no sink ready
  assign out_valid = send;
  assign out_data  = hold_data;
  assign out_last  = hold_last;

  // sink granted more than it may hold
  a_grant_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    out_credit_grant && !send |-> credits != OUT_CREDIT_W'(OUT_CREDIT_MAX))
    else $error("downstream credit grant beyond maximum");

endmodule

//--- hdl/flit_pkg.sv
package flit_pkg;

  ////////////////////
  // beat layout
  ////////////////////

  localparam int BEAT_W = 32;

  // source lane field, top nibble of the header
  localparam int SRC_LANE_W = 4;

  // header view of the first beat
  typedef struct packed {
    logic [SRC_LANE_W-1:0] src_lane;
    // carried unchanged
    logic [11:0]           flow_id;
    // beat count incl header
    logic [15:0]           pkt_len;
  } hdr_t;

  // one word, two readings
  typedef union packed {
    logic [BEAT_W-1:0] raw;
    hdr_t              hdr;
  } beat_u;

endpackage

//--- hdl/lane_if.sv
`timescale 1ns/1ps

interface lane_if import merge_cfg_pkg::*, flit_pkg::*; ();

  // head of each lane fifo
  logic [NUM_LANES-1:0]             head_valid;
  logic [NUM_LANES-1:0][BEAT_W-1:0] head_data;
  logic [NUM_LANES-1:0]             head_last;

  // one-hot pop strobes back to the fifos
  logic [NUM_LANES-1:0]             pop;

  modport ingress (
    output head_valid, head_data, head_last,
    input  pop
  );

  modport arbiter (
    input  head_valid, head_data, head_last,
    output pop
  );

endinterface

//--- hdl/lane_ingress.sv
`timescale 1ns/1ps

module lane_ingress import merge_cfg_pkg::*, flit_pkg::*; (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [NUM_LANES-1:0]             in_valid,
  input  logic [NUM_LANES-1:0][BEAT_W-1:0] in_data,
  input  logic [NUM_LANES-1:0]             in_last,
  output logic [NUM_LANES-1:0]             in_credit,
  lane_if.ingress                          lanes
);

  ////////////////////
  // per-lane fifos
  ////////////////////

  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    // beat plus last flag in the top bit
    logic [BEAT_W:0]       mem [LANE_CREDITS];
    logic [LANE_PTR_W-1:0] wr_ptr;
    logic [LANE_PTR_W-1:0] rd_ptr;
    logic [LANE_PTR_W:0]   count;
    logic                  full;
    logic                  wr_en;
    logic                  rd_en;

    assign full  = (count == (LANE_PTR_W + 1)'(LANE_CREDITS));
    // a full fifo drops the beat, the assertion below catches it
    assign wr_en = in_valid[l] && !full;
    assign rd_en = lanes.pop[l];

    // storage
    always_ff @(posedge clk) begin
      if (wr_en) begin
        mem[wr_ptr] <= {in_last[l], in_data[l]};
      end
    end

    // pointers wrap at depth
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
      end else begin
        if (wr_en) begin
          wr_ptr <= (wr_ptr == LANE_PTR_W'(LANE_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (rd_en) begin
          rd_ptr <= (rd_ptr == LANE_PTR_W'(LANE_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
        end
      end
    end

    // fill level
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        count <= '0;
      end else begin
        case ({wr_en, rd_en})
          2'b10:   count <= count + 1'b1;
          2'b01:   count <= count - 1'b1;
          default: count <= count;
        endcase
      end
    end

    // head beat, visible the cycle after the write
    assign lanes.head_valid[l] = (count != '0);
    assign {lanes.head_last[l], lanes.head_data[l]} = mem[rd_ptr];

    // source sent beyond its credits
    a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
      in_valid[l] |-> !full)
      else $error("lane %0d wrote into a full fifo", l);
  end

  ////////////////////
  // credit return
  ////////////////////

  // one pulse per popped beat, a cycle after the pop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_credit <= '0;
    end else begin
      in_credit <= lanes.pop;
    end
  end

endmodule

//--- hdl/merge_cfg_pkg.sv
package merge_cfg_pkg;

  ////////////////////
  // source lanes
  ////////////////////

  localparam int NUM_LANES = 4;
  localparam int LANE_W = $clog2(NUM_LANES);

  // fifo depth per lane, also the initial credits of each source
  localparam int LANE_CREDITS = 4;
  localparam int LANE_PTR_W = $clog2(LANE_CREDITS);

  ////////////////////
  // downstream credits
  ////////////////////

  localparam int OUT_CREDIT_MAX = 8;
  // room for the full count, not just max-1
  localparam int OUT_CREDIT_W = $clog2(OUT_CREDIT_MAX + 1);

endpackage

//--- hdl/packet_fanin_arbiter.sv
`timescale 1ns/1ps

module packet_fanin_arbiter import merge_cfg_pkg::*, flit_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  lane_if.arbiter lanes,
  beat_if.source  out
);

  logic              locked;
  logic [LANE_W-1:0] lock_lane;
  logic [LANE_W-1:0] pick_lane;
  logic [LANE_W-1:0] sel_lane;
  logic              sop;
  logic              can_load;
  logic              take;
  beat_u             cur;
  logic              valid_q;
  logic [BEAT_W-1:0] data_q;
  logic              last_q;

  ////////////////////
  // lane selection
  ////////////////////

  // scan downward so the lowest waiting lane wins
  always_comb begin
    pick_lane = '0;
    for (int i = NUM_LANES - 1; i >= 0; i--) begin
      if (lanes.head_valid[i]) begin
        pick_lane = LANE_W'(i);
      end
    end
  end

  // stay on the locked lane mid-packet even if it runs dry
  assign sel_lane = locked ? lock_lane : pick_lane;
  assign sop      = !locked;

  // output reg empty or draining
  assign can_load = !valid_q || out.ready;
  assign take     = can_load && lanes.head_valid[sel_lane];
  assign lanes.pop = take ? (NUM_LANES'(1) << sel_lane) : '0;

  // stamp the winning lane into the header
  always_comb begin
    cur.raw = lanes.head_data[sel_lane];
    if (sop) begin
      cur.hdr.src_lane = SRC_LANE_W'(sel_lane);
    end
  end

  // packet lock released by the popped last beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      locked    <= 1'b0;
      lock_lane <= '0;
    end else if (take) begin
      locked    <= !lanes.head_last[sel_lane];
      lock_lane <= sel_lane;
    end
  end

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (take) begin
      valid_q <= 1'b1;
    end else if (out.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      data_q <= cur.raw;
      last_q <= lanes.head_last[sel_lane];
    end
  end

  assign out.valid = valid_q;
  assign out.data  = data_q;
  assign out.last  = last_q;

endmodule

//--- hdl/packet_merger_top.sv
`timescale 1ns/1ps

module packet_merger_top import merge_cfg_pkg::*, flit_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [NUM_LANES-1:0]        in_valid,
  input  logic [NUM_LANES*BEAT_W-1:0] in_data,
  input  logic [NUM_LANES-1:0]        in_last,
  output logic [NUM_LANES-1:0]        in_credit,
  output logic                        out_valid,
  output logic [BEAT_W-1:0]           out_data,
  output logic                        out_last,
  input  logic                        out_credit_grant
);

  ////////////////////
  // internal buses
  ////////////////////

  lane_if i_lane_bus ();
  beat_if i_beat_bus ();

  // fifos and credit return
  lane_ingress i_lane_ingress (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_last   (in_last),
    .in_credit (in_credit),
    .lanes     (i_lane_bus)
  );

  // priority fan-in with packet lock
  packet_fanin_arbiter i_packet_fanin_arbiter (
    .clk   (clk),
    .rst_n (rst_n),
    .lanes (i_lane_bus),
    .out   (i_beat_bus)
  );

  // downstream credit gate
  credit_egress i_credit_egress (
    .clk              (clk),
    .rst_n            (rst_n),
    .in               (i_beat_bus),
    .out_valid        (out_valid),
    .out_data         (out_data),
    .out_last         (out_last),
    .out_credit_grant (out_credit_grant)
  );

endmodule

//--- test/merger_stim.txt
# scenario <name> <grant mode: 0 holds grants until lanes are loaded, 1 random gaps>
# pkt <lane> <beats> then <hex beat> <last> per beat ; exp <beats> then <hex beat> <last> ; run
scenario passthrough 1
pkt 2 4 f5a30004 0 11112222 0 33334444 0 55556666 1
exp 4 25a30004 0 11112222 0 33334444 0 55556666 1
run
scenario priority_lock 0
pkt 3 2 01230002 0 deadbeef 1
pkt 1 3 04560003 0 a1a1a1a1 0 b2b2b2b2 1
pkt 0 2 07890002 0 c0c0c0c0 1
exp 7 07890002 0 c0c0c0c0 1
      14560003 0 a1a1a1a1 0 b2b2b2b2 1
      31230002 0 deadbeef 1
run
scenario backpressure 1
pkt 0 3 70010003 0 20000001 0 20000002 1
pkt 1 6 eabc0006 0 10000001 0 10000002 0 10000003 0 10000004 0 10000005 1
pkt 2 2 00ff0002 0 30000001 1
exp 11 00010003 0 20000001 0 20000002 1
       1abc0006 0 10000001 0 10000002 0 10000003 0 10000004 0 10000005 1
       20ff0002 0 30000001 1
run

//--- test/packet_merger_tb.sv
`timescale 1ns/1ps

module packet_merger_tb import merge_cfg_pkg::*, flit_pkg::*; ;

  // cycles allowed for any single wait
  localparam int CYCLE_LIMIT = 2000;

  logic                        clk;
  logic                        rst_n;
  logic [NUM_LANES-1:0]        in_valid;
  logic [NUM_LANES*BEAT_W-1:0] in_data;
  logic [NUM_LANES-1:0]        in_last;
  logic [NUM_LANES-1:0]        in_credit;
  logic                        out_valid;
  logic [BEAT_W-1:0]           out_data;
  logic                        out_last;
  logic                        out_credit_grant;

  // current scenario with {last, beat} per entry
  string           scen_name;
  int              scen_mode;
  logic [BEAT_W:0] lane_q [NUM_LANES][$];
  logic [BEAT_W:0] exp_q [$];

  packet_merger_top i_packet_merger_top (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_valid         (in_valid),
    .in_data          (in_data),
    .in_last          (in_last),
    .in_credit        (in_credit),
    .out_valid        (out_valid),
    .out_data         (out_data),
    .out_last         (out_last),
    .out_credit_grant (out_credit_grant)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // reporting
  ////////////////////

  task automatic abort_run(input string what);
    $display("ERROR: %s", what);
    $display("Verification failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [BEAT_W:0] expected,
                             input logic [BEAT_W:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      $display("Verification failed");
      $fatal(1, "value mismatch");
    end
  endtask

  ////////////////////
  // one scenario
  ////////////////////

  task automatic run_scenario();
    int   credits [NUM_LANES];
    int   sent [NUM_LANES];
    int   returned [NUM_LANES];
    int   grants;
    int   out_idx;
    int   gap;
    int   cycles;
    logic loaded;
    logic pending;
    for (int l = 0; l < NUM_LANES; l++) begin
      credits[l]  = LANE_CREDITS;
      sent[l]     = 0;
      returned[l] = 0;
    end
    grants  = 0;
    out_idx = 0;
    gap     = 0;
    cycles  = 0;
    while (out_idx < exp_q.size()) begin
      // sample mid-cycle where outputs have settled
      @(negedge clk);
      for (int l = 0; l < NUM_LANES; l++) begin
        if (in_credit[l]) begin
          credits[l]++;
          returned[l]++;
        end
      end
      if (out_valid) begin
        // a grant still on the wire only counts from the next edge
        if (out_idx >= grants - int'(out_credit_grant)) begin
          abort_run("a beat left the merger without a downstream credit");
        end
        check_value(scen_name, exp_q[out_idx], {out_last, out_data});
        out_idx++;
      end
      @(posedge clk);
      #1;
      // lane sources send one beat per held credit
      loaded = 1'b1;
      for (int l = 0; l < NUM_LANES; l++) begin
        if (lane_q[l].size() != 0 && credits[l] > 0) begin
          {in_last[l], in_data[l*BEAT_W +: BEAT_W]} = lane_q[l].pop_front();
          in_valid[l] = 1'b1;
          credits[l]--;
          sent[l]++;
        end else begin
          in_valid[l] = 1'b0;
        end
        if (lane_q[l].size() != 0) begin
          loaded = 1'b0;
        end
      end
      // sink grants held back in mode 0 until every lane is loaded
      out_credit_grant = 1'b0;
      if ((scen_mode == 1 || loaded) && grants < exp_q.size() &&
          grants - out_idx < OUT_CREDIT_MAX) begin
        if (gap == 0) begin
          out_credit_grant = 1'b1;
          grants++;
          gap = $urandom_range(3, 0);
        end else begin
          gap--;
        end
      end
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
        abort_run($sformatf("output beat %0d of %s never arrived", out_idx, scen_name));
      end
    end
    out_credit_grant = 1'b0;
    // every popped beat owes its source one credit
    cycles  = 0;
    pending = 1'b1;
    while (pending) begin
      pending = 1'b0;
      for (int l = 0; l < NUM_LANES; l++) begin
        if (returned[l] < sent[l]) begin
          pending = 1'b1;
        end
      end
      if (pending) begin
        @(negedge clk);
        for (int l = 0; l < NUM_LANES; l++) begin
          if (in_credit[l]) begin
            returned[l]++;
          end
        end
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
          abort_run("credit return pulses never caught up with the beats sent");
        end
      end
    end
    for (int l = 0; l < NUM_LANES; l++) begin
      check_value($sformatf("%s credits lane %0d", scen_name, l), sent[l], returned[l]);
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int              fd;
    int              n;
    int              lane;
    int              nbeats;
    int              last;
    int              scenarios;
    logic [BEAT_W-1:0] beat;
    string           tok;
    string           line;
    void'($urandom(32'hace7_dab2));
    rst_n            = 1'b0;
    in_valid         = '0;
    in_data          = '0;
    in_last          = '0;
    out_credit_grant = 1'b0;
    scenarios        = 0;
    // outputs quiet while in reset
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      check_value("reset out_valid", '0, out_valid);
      check_value("reset in_credit", '0, in_credit);
    end
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    fd = $fopen("test/merger_stim.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open test/merger_stim.txt");
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok == "#") begin
        void'($fgets(line, fd));
      end else if (tok == "scenario") begin
        n = $fscanf(fd, "%s %d", scen_name, scen_mode);
        if (n != 2) begin
          abort_run("malformed scenario line in stimulus file");
        end
        for (int l = 0; l < NUM_LANES; l++) begin
          lane_q[l].delete();
        end
        exp_q.delete();
      end else if (tok == "pkt") begin
        n = $fscanf(fd, "%d %d", lane, nbeats);
        if (n != 2 || lane < 0 || lane >= NUM_LANES) begin
          abort_run("malformed packet line in stimulus file");
        end
        for (int i = 0; i < nbeats; i++) begin
          n = $fscanf(fd, "%h %d", beat, last);
          lane_q[lane].push_back({last[0], beat});
        end
      end else if (tok == "exp") begin
        n = $fscanf(fd, "%d", nbeats);
        for (int i = 0; i < nbeats; i++) begin
          n = $fscanf(fd, "%h %d", beat, last);
          exp_q.push_back({last[0], beat});
        end
      end else if (tok == "run") begin
        run_scenario();
        scenarios++;
      end else begin
        abort_run({"unknown token in stimulus file: ", tok});
      end
    end
    $fclose(fd);
    if (scenarios == 0) begin
      $display("ERROR: the stimulus file held no scenario");
      $display("Verification failed");
      $fatal(1, "no scenario");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule
